//--- src/cpu_pkg.sv
package cpu_pkg;

	localparam int word_size = 16;
	typedef logic [word_size-1:0] word_t;

	localparam int reg_count = 4;
	typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

	// jal and jrl link here
	localparam reg_addr_t link_reg = 2'd2;

	typedef enum logic [3:0] {
		op_bne = 4'd0,
		op_beq = 4'd1,
		op_bgz = 4'd2,
		op_blz = 4'd3,
		op_adi = 4'd4,
		op_ori = 4'd5,
		op_lhi = 4'd6,
		op_lwd = 4'd7,
		op_swd = 4'd8,
		op_jmp = 4'd9,
		op_jal = 4'd10,
		op_rtype = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_not = 6'd4,
		fn_tcp = 6'd5,
		fn_shl = 6'd6,
		fn_shr = 6'd7,
		fn_jpr = 6'd25,
		fn_jrl = 6'd26,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} func_e;

	typedef enum logic [2:0] {
		if_s,
		id_s,
		ex_s,
		mem_s,
		wb_s,
		halt_s
	} state_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_not,
		alu_tcp,
		alu_shl,
		alu_shr,
		alu_pass_b,
		alu_ne,
		alu_eq,
		alu_gz,
		alu_lz
	} alu_op_e;

	// next pc sources
	localparam logic [1:0] pc_src_seq = 2'd0;
	localparam logic [1:0] pc_src_jump = 2'd1;
	localparam logic [1:0] pc_src_reg = 2'd2;
	localparam logic [1:0] pc_src_branch = 2'd3;

	// register write-back sources and destinations
	localparam logic [1:0] wb_alu = 2'd0;
	localparam logic [1:0] wb_mem = 2'd1;
	localparam logic [1:0] wb_pc1 = 2'd2;
	localparam logic [1:0] dst_rd = 2'd0;
	localparam logic [1:0] dst_rt = 2'd1;
	localparam logic [1:0] dst_link = 2'd2;

	// alu operand sources
	localparam logic alu_a_reg = 1'b0;
	localparam logic alu_a_pc1 = 1'b1;
	localparam logic alu_b_reg = 1'b0;
	localparam logic alu_b_imm = 1'b1;

endpackage

//--- src/cpu_ctrl_if.sv
interface cpu_ctrl_if;
	logic pc_write;
	logic ir_write;
	logic mem_read;
	logic mem_write;
	// high selects the alu output register as memory address
	logic i_or_d;
	logic reg_write;
	logic [1:0] reg_dst_sel;
	logic [1:0] wb_sel;
	logic alu_a_sel;
	logic alu_b_sel;
	cpu_pkg::alu_op_e alu_op;
	logic [1:0] pc_src;
	logic wwd;
	logic halt;
	logic new_inst;

	// decoded instruction fields and branch result
	cpu_pkg::opcode_e opcode;
	cpu_pkg::func_e func;
	logic bcond;

	modport control (
		output pc_write, ir_write, mem_read, mem_write, i_or_d,
		output reg_write, reg_dst_sel, wb_sel, alu_a_sel, alu_b_sel, alu_op,
		output pc_src, wwd, halt, new_inst,
		input opcode, func, bcond
	);

	modport datapath (
		input pc_write, ir_write, mem_read, mem_write, i_or_d,
		input reg_write, reg_dst_sel, wb_sel, alu_a_sel, alu_b_sel, alu_op,
		input pc_src, wwd, halt, new_inst,
		output opcode, func, bcond
	);
endinterface

//--- src/register_file.sv
module register_file (
	input logic clk,
	input cpu_pkg::reg_addr_t read1,
	input cpu_pkg::reg_addr_t read2,
	input cpu_pkg::reg_addr_t write_reg,
	input cpu_pkg::word_t write_data,
	input logic reg_write,
	output cpu_pkg::word_t read_out1,
	output cpu_pkg::word_t read_out2
);

	cpu_pkg::word_t regs [cpu_pkg::reg_count];

	// asynchronous reads
	assign read_out1 = regs[read1];
	assign read_out2 = regs[read2];

	always_ff @(posedge clk) begin
		if (reg_write) begin
			regs[write_reg] <= write_data;
		end
	end

endmodule

//--- src/alu.sv
module alu (
	input cpu_pkg::word_t a,
	input cpu_pkg::word_t b,
	input cpu_pkg::alu_op_e op,
	output cpu_pkg::word_t result,
	output logic bcond
);

	localparam int msb = cpu_pkg::word_size - 1;

	logic a_zero;

	assign a_zero = (a == '0);

	always_comb begin
		case (op)
			cpu_pkg::alu_add: result = a + b;
			cpu_pkg::alu_sub: result = a - b;
			cpu_pkg::alu_and: result = a & b;
			cpu_pkg::alu_or: result = a | b;
			cpu_pkg::alu_not: result = ~a;
			cpu_pkg::alu_tcp: result = ~a + 1'b1;
			cpu_pkg::alu_shl: result = {a[msb-1:0], 1'b0};
			// arithmetic shift keeps the sign
			cpu_pkg::alu_shr: result = {a[msb], a[msb:1]};
			cpu_pkg::alu_pass_b: result = b;
			default: result = a - b;
		endcase
	end

	// branch compares treat rs and rt as signed
	always_comb begin
		case (op)
			cpu_pkg::alu_ne: bcond = (a != b);
			cpu_pkg::alu_eq: bcond = (a == b);
			cpu_pkg::alu_gz: bcond = !a[msb] && !a_zero;
			cpu_pkg::alu_lz: bcond = a[msb];
			default: bcond = 1'b0;
		endcase
	end

endmodule

//--- src/control_unit.sv
module control_unit (
	input logic clk,
	input logic reset_n,
	cpu_ctrl_if.control ctrl
);

	cpu_pkg::state_e state;
	cpu_pkg::state_e state_next;
	logic is_rtype;
	logic is_branch;

	function automatic cpu_pkg::alu_op_e ex_alu_op(
		input cpu_pkg::opcode_e opcode,
		input cpu_pkg::func_e func
	);
		case (opcode)
			cpu_pkg::op_rtype: begin
				case (func)
					cpu_pkg::fn_sub: return cpu_pkg::alu_sub;
					cpu_pkg::fn_and: return cpu_pkg::alu_and;
					cpu_pkg::fn_orr: return cpu_pkg::alu_or;
					cpu_pkg::fn_not: return cpu_pkg::alu_not;
					cpu_pkg::fn_tcp: return cpu_pkg::alu_tcp;
					cpu_pkg::fn_shl: return cpu_pkg::alu_shl;
					cpu_pkg::fn_shr: return cpu_pkg::alu_shr;
					default: return cpu_pkg::alu_add;
				endcase
			end
			cpu_pkg::op_ori: return cpu_pkg::alu_or;
			cpu_pkg::op_lhi: return cpu_pkg::alu_pass_b;
			cpu_pkg::op_bne: return cpu_pkg::alu_ne;
			cpu_pkg::op_beq: return cpu_pkg::alu_eq;
			cpu_pkg::op_bgz: return cpu_pkg::alu_gz;
			cpu_pkg::op_blz: return cpu_pkg::alu_lz;
			// adi and the lwd/swd address
			default: return cpu_pkg::alu_add;
		endcase
	endfunction

	assign is_rtype = (ctrl.opcode == cpu_pkg::op_rtype);
	assign is_branch = (ctrl.opcode == cpu_pkg::op_bne) || (ctrl.opcode == cpu_pkg::op_beq)
		|| (ctrl.opcode == cpu_pkg::op_bgz) || (ctrl.opcode == cpu_pkg::op_blz);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= cpu_pkg::if_s;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		ctrl.pc_write = 1'b0;
		ctrl.ir_write = 1'b0;
		ctrl.mem_read = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.i_or_d = 1'b0;
		ctrl.reg_write = 1'b0;
		ctrl.reg_dst_sel = cpu_pkg::dst_rd;
		ctrl.wb_sel = cpu_pkg::wb_alu;
		ctrl.alu_a_sel = cpu_pkg::alu_a_reg;
		ctrl.alu_b_sel = cpu_pkg::alu_b_reg;
		ctrl.alu_op = cpu_pkg::alu_add;
		ctrl.pc_src = cpu_pkg::pc_src_seq;
		ctrl.wwd = 1'b0;
		ctrl.halt = 1'b0;
		ctrl.new_inst = 1'b0;
		state_next = state;

		case (state)
			cpu_pkg::if_s: begin
				ctrl.mem_read = 1'b1;
				ctrl.ir_write = 1'b1;
				state_next = cpu_pkg::id_s;
			end
			cpu_pkg::id_s: begin
				// branch target pc+1+imm lands in the alu output register
				ctrl.alu_a_sel = cpu_pkg::alu_a_pc1;
				ctrl.alu_b_sel = cpu_pkg::alu_b_imm;
				state_next = cpu_pkg::ex_s;
				case (ctrl.opcode)
					cpu_pkg::op_jmp, cpu_pkg::op_jal: begin
						ctrl.pc_write = 1'b1;
						ctrl.pc_src = cpu_pkg::pc_src_jump;
						ctrl.reg_write = (ctrl.opcode == cpu_pkg::op_jal);
						ctrl.reg_dst_sel = cpu_pkg::dst_link;
						ctrl.wb_sel = cpu_pkg::wb_pc1;
						ctrl.new_inst = 1'b1;
						state_next = cpu_pkg::if_s;
					end
					cpu_pkg::op_rtype: begin
						case (ctrl.func)
							cpu_pkg::fn_jpr, cpu_pkg::fn_jrl: begin
								ctrl.pc_write = 1'b1;
								ctrl.pc_src = cpu_pkg::pc_src_reg;
								ctrl.reg_write = (ctrl.func == cpu_pkg::fn_jrl);
								ctrl.reg_dst_sel = cpu_pkg::dst_link;
								ctrl.wb_sel = cpu_pkg::wb_pc1;
								ctrl.new_inst = 1'b1;
								state_next = cpu_pkg::if_s;
							end
							cpu_pkg::fn_wwd: begin
								ctrl.wwd = 1'b1;
								ctrl.pc_write = 1'b1;
								ctrl.new_inst = 1'b1;
								state_next = cpu_pkg::if_s;
							end
							cpu_pkg::fn_hlt: begin
								ctrl.new_inst = 1'b1;
								state_next = cpu_pkg::halt_s;
							end
							default: state_next = cpu_pkg::ex_s;
						endcase
					end
					default: state_next = cpu_pkg::ex_s;
				endcase
			end
			cpu_pkg::ex_s: begin
				ctrl.alu_op = ex_alu_op(ctrl.opcode, ctrl.func);
				if (!is_rtype && !is_branch) begin
					ctrl.alu_b_sel = cpu_pkg::alu_b_imm;
				end
				if (is_branch) begin
					ctrl.pc_write = 1'b1;
					ctrl.pc_src = ctrl.bcond ? cpu_pkg::pc_src_branch : cpu_pkg::pc_src_seq;
					ctrl.new_inst = 1'b1;
					state_next = cpu_pkg::if_s;
				end else if (ctrl.opcode == cpu_pkg::op_lwd || ctrl.opcode == cpu_pkg::op_swd) begin
					state_next = cpu_pkg::mem_s;
				end else begin
					state_next = cpu_pkg::wb_s;
				end
			end
			cpu_pkg::mem_s: begin
				ctrl.i_or_d = 1'b1;
				if (ctrl.opcode == cpu_pkg::op_swd) begin
					ctrl.mem_write = 1'b1;
					ctrl.pc_write = 1'b1;
					ctrl.new_inst = 1'b1;
					state_next = cpu_pkg::if_s;
				end else begin
					ctrl.mem_read = 1'b1;
					state_next = cpu_pkg::wb_s;
				end
			end
			cpu_pkg::wb_s: begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst_sel = is_rtype ? cpu_pkg::dst_rd : cpu_pkg::dst_rt;
				ctrl.wb_sel = (ctrl.opcode == cpu_pkg::op_lwd) ? cpu_pkg::wb_mem : cpu_pkg::wb_alu;
				ctrl.pc_write = 1'b1;
				ctrl.new_inst = 1'b1;
				state_next = cpu_pkg::if_s;
			end
			cpu_pkg::halt_s: begin
				ctrl.halt = 1'b1;
			end
			default: state_next = cpu_pkg::if_s;
		endcase
	end

endmodule

//--- src/cpu.sv
module cpu (
	input logic clk,
	input logic reset_n,
	output logic read_m,
	output logic write_m,
	output cpu_pkg::word_t address,
	inout wire cpu_pkg::word_t data,
	output cpu_pkg::word_t num_inst,
	output cpu_pkg::word_t output_port,
	output logic is_halted
);

	localparam int msb = cpu_pkg::word_size - 1;
	localparam int imm_width = 8;
	localparam int target_width = 12;

	cpu_pkg::word_t pc;
	cpu_pkg::word_t ir;
	cpu_pkg::word_t alu_out;
	cpu_pkg::word_t mdr;

	cpu_pkg::word_t pc_1;
	cpu_pkg::word_t pc_next;
	cpu_pkg::word_t jump_target;
	cpu_pkg::word_t immediate;
	cpu_pkg::word_t alu_a;
	cpu_pkg::word_t alu_b;
	cpu_pkg::word_t alu_result;
	cpu_pkg::word_t read_out1;
	cpu_pkg::word_t read_out2;
	cpu_pkg::word_t write_data;
	cpu_pkg::reg_addr_t write_reg;

	cpu_ctrl_if ctrl_if ();

	// instruction fields
	assign ctrl_if.opcode = cpu_pkg::opcode_e'(ir[msb:msb-3]);
	assign ctrl_if.func = cpu_pkg::func_e'(ir[5:0]);

	assign pc_1 = pc + 1'b1;
	assign jump_target = {pc[msb:target_width], ir[target_width-1:0]};

	always_comb begin
		case (ctrl_if.opcode)
			cpu_pkg::op_ori: immediate = {{(cpu_pkg::word_size-imm_width){1'b0}}, ir[imm_width-1:0]};
			cpu_pkg::op_lhi: immediate = {ir[imm_width-1:0], {(cpu_pkg::word_size-imm_width){1'b0}}};
			default: immediate = {{(cpu_pkg::word_size-imm_width){ir[imm_width-1]}},
				ir[imm_width-1:0]};
		endcase
	end

	assign alu_a = (ctrl_if.alu_a_sel == cpu_pkg::alu_a_pc1) ? pc_1 : read_out1;
	assign alu_b = (ctrl_if.alu_b_sel == cpu_pkg::alu_b_imm) ? immediate : read_out2;

	always_comb begin
		case (ctrl_if.reg_dst_sel)
			cpu_pkg::dst_rd: write_reg = ir[7:6];
			cpu_pkg::dst_rt: write_reg = ir[9:8];
			default: write_reg = cpu_pkg::link_reg;
		endcase
	end

	always_comb begin
		case (ctrl_if.wb_sel)
			cpu_pkg::wb_mem: write_data = mdr;
			cpu_pkg::wb_pc1: write_data = pc_1;
			default: write_data = alu_out;
		endcase
	end

	always_comb begin
		case (ctrl_if.pc_src)
			cpu_pkg::pc_src_jump: pc_next = jump_target;
			cpu_pkg::pc_src_reg: pc_next = read_out1;
			cpu_pkg::pc_src_branch: pc_next = alu_out;
			default: pc_next = pc_1;
		endcase
	end

	// memory bus
	assign read_m = ctrl_if.mem_read;
	assign write_m = ctrl_if.mem_write;
	assign address = ctrl_if.i_or_d ? alu_out : pc;
	// swd stores rt
	assign data = ctrl_if.mem_write ? read_out2 : 'z;

	assign is_halted = ctrl_if.halt;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			num_inst <= '0;
			output_port <= '0;
		end else begin
			if (ctrl_if.pc_write) begin
				pc <= pc_next;
			end
			if (ctrl_if.new_inst) begin
				num_inst <= num_inst + 1'b1;
			end
			if (ctrl_if.wwd) begin
				output_port <= read_out1;
			end
		end
	end

	// alu output is held one cycle for the next state
	always_ff @(posedge clk) begin
		if (ctrl_if.ir_write) begin
			ir <= data;
		end
		if (ctrl_if.mem_read) begin
			mdr <= data;
		end
		alu_out <= alu_result;
	end

	control_unit control_unit_inst (
		.clk(clk),
		.reset_n(reset_n),
		.ctrl(ctrl_if.control)
	);

	register_file register_file_inst (
		.clk(clk),
		.read1(ir[11:10]),
		.read2(ir[9:8]),
		.write_reg(write_reg),
		.write_data(write_data),
		.reg_write(ctrl_if.reg_write),
		.read_out1(read_out1),
		.read_out2(read_out2)
	);

	alu alu_inst (
		.a(alu_a),
		.b(alu_b),
		.op(ctrl_if.alu_op),
		.result(alu_result),
		.bcond(ctrl_if.bcond)
	);

endmodule

//--- verification/cpu_ref_model.svh
`ifndef cpu_ref_model_svh
`define cpu_ref_model_svh

localparam int ref_step_limit = 4096;

// instruction set interpreter stepping one instruction per loop pass
function automatic void ref_run(
	input mem_image_t image,
	output cpu_pkg::word_t outs[$],
	output int count,
	output bit halted,
	output mem_image_t final_mem
);
	cpu_pkg::word_t regs [cpu_pkg::reg_count];
	cpu_pkg::word_t pc;
	cpu_pkg::word_t pc_next;
	cpu_pkg::word_t inst;
	cpu_pkg::word_t rs_val;
	cpu_pkg::word_t rt_val;
	cpu_pkg::word_t imm_s;
	logic [1:0] rs;
	logic [1:0] rt;
	logic [1:0] rd;

	final_mem = image;
	outs = {};
	count = 0;
	halted = 1'b0;
	pc = '0;
	foreach (regs[i]) begin
		regs[i] = '0;
	end
	while (!halted && count < ref_step_limit) begin
		inst = final_mem[pc[7:0]];
		rs = inst[11:10];
		rt = inst[9:8];
		rd = inst[7:6];
		rs_val = regs[rs];
		rt_val = regs[rt];
		imm_s = cpu_pkg::word_t'($signed(inst[7:0]));
		pc_next = pc + 16'd1;
		count++;
		case (inst[15:12])
			cpu_pkg::op_adi: regs[rt] = rs_val + imm_s;
			cpu_pkg::op_ori: regs[rt] = rs_val | {8'h00, inst[7:0]};
			cpu_pkg::op_lhi: regs[rt] = {inst[7:0], 8'h00};
			cpu_pkg::op_lwd: regs[rt] = final_mem[8'(rs_val + imm_s)];
			cpu_pkg::op_swd: final_mem[8'(rs_val + imm_s)] = rt_val;
			cpu_pkg::op_bne: if (rs_val != rt_val) pc_next = pc + 16'd1 + imm_s;
			cpu_pkg::op_beq: if (rs_val == rt_val) pc_next = pc + 16'd1 + imm_s;
			cpu_pkg::op_bgz: if ($signed(rs_val) > 0) pc_next = pc + 16'd1 + imm_s;
			cpu_pkg::op_blz: if ($signed(rs_val) < 0) pc_next = pc + 16'd1 + imm_s;
			cpu_pkg::op_jmp: pc_next = {pc[15:12], inst[11:0]};
			cpu_pkg::op_jal: begin
				regs[cpu_pkg::link_reg] = pc + 16'd1;
				pc_next = {pc[15:12], inst[11:0]};
			end
			cpu_pkg::op_rtype: begin
				case (inst[5:0])
					cpu_pkg::fn_add: regs[rd] = rs_val + rt_val;
					cpu_pkg::fn_sub: regs[rd] = rs_val - rt_val;
					cpu_pkg::fn_and: regs[rd] = rs_val & rt_val;
					cpu_pkg::fn_orr: regs[rd] = rs_val | rt_val;
					cpu_pkg::fn_not: regs[rd] = ~rs_val;
					cpu_pkg::fn_tcp: regs[rd] = 16'd0 - rs_val;
					cpu_pkg::fn_shl: regs[rd] = rs_val << 1;
					cpu_pkg::fn_shr: regs[rd] = cpu_pkg::word_t'($signed(rs_val) >>> 1);
					cpu_pkg::fn_wwd: outs.push_back(rs_val);
					cpu_pkg::fn_jpr: pc_next = rs_val;
					cpu_pkg::fn_jrl: begin
						regs[cpu_pkg::link_reg] = pc + 16'd1;
						pc_next = rs_val;
					end
					cpu_pkg::fn_hlt: halted = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
		if (!halted) begin
			pc = pc_next;
		end
	end
endfunction

task automatic compare_word(input string what, input cpu_pkg::word_t got,
	input cpu_pkg::word_t expected);
	if (got !== expected) begin
		$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		abort_run();
	end
endtask

task automatic compare_flag(input string what, input logic got, input logic expected);
	if (got !== expected) begin
		$display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, expected);
		abort_run();
	end
endtask

`endif

//--- verification/cpu_tb.sv
module cpu_tb;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int clk_period = 100;
	localparam int reset_cycles = 3;
	localparam int mem_words = 256;
	localparam int data_base = 'hc0;
	localparam int halt_hold_cycles = 10;
	localparam logic [31:0] lfsr_seed = 32'hd40482b7;
	localparam logic [31:0] lfsr_taps = 32'h80200003;

	typedef cpu_pkg::word_t mem_image_t [mem_words];

	logic clk;
	logic reset_n;
	logic read_m;
	logic write_m;
	logic is_halted;
	cpu_pkg::word_t address;
	cpu_pkg::word_t num_inst;
	cpu_pkg::word_t output_port;
	wire cpu_pkg::word_t data;

	mem_image_t mem;
	mem_image_t image;
	mem_image_t ref_mem;
	cpu_pkg::word_t ref_outs[$];
	cpu_pkg::word_t expected_changes[$];
	int ref_count;
	bit ref_halted;
	int prog_len;
	logic [31:0] lfsr_state;
	logic checking_port;
	logic counting;
	cpu_pkg::word_t seen_port;
	int port_index;
	int cycle_count;
	int cycle_limit;

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	`include "cpu_ref_model.svh"

	cpu cpu_inst (
		.clk(clk),
		.reset_n(reset_n),
		.read_m(read_m),
		.write_m(write_m),
		.address(address),
		.data(data),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	// memory answers reads in the same cycle
	assign data = (read_m === 1'b1) ? mem[address[7:0]] : 'z;

	always @(posedge clk) begin : memory_model
		if (reset_n === 1'b1 && (read_m === 1'b1 || write_m === 1'b1)) begin
			if (read_m === 1'b1 && write_m === 1'b1) begin
				$display("error: read_m and write_m are high together at %0t ns", $time);
				abort_run();
			end else if (address >= mem_words) begin
				$display("error: memory address %h is out of range", address);
				abort_run();
			end else if (write_m === 1'b1) begin
				mem[address[7:0]] <= data;
			end
		end
	end

	always @(posedge clk) begin : watchdog
		if (counting) begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= cycle_limit) begin
				$display("error: cpu did not halt in time");
				abort_run();
			end
		end
	end

	always @(negedge clk) begin : port_compare
		if (checking_port && output_port !== seen_port) begin
			if (port_index >= expected_changes.size()) begin
				$display("error: output_port changed more often than the reference program");
				abort_run();
			end else begin
				compare_word($sformatf("output_port change %0d", port_index), output_port,
					expected_changes[port_index]);
				seen_port = output_port;
				port_index++;
			end
		end
	end

	function automatic logic [31:0] lfsr_advance(input logic [31:0] state);
		logic [31:0] next;

		next = state >> 1;
		if (state[0]) begin
			next = next ^ lfsr_taps;
		end
		return next;
	endfunction

	// one lfsr step per bit
	function automatic logic [15:0] random_bits(input int count);
		logic [15:0] value;

		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[14:0], lfsr_state[0]};
			lfsr_state = lfsr_advance(lfsr_state);
		end
		return value;
	endfunction

	function automatic cpu_pkg::word_t encode_r(input cpu_pkg::func_e fn,
		input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt,
		input cpu_pkg::reg_addr_t rd);
		return {cpu_pkg::op_rtype, rs, rt, rd, fn};
	endfunction

	function automatic cpu_pkg::word_t encode_i(input cpu_pkg::opcode_e op,
		input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic cpu_pkg::word_t encode_j(input cpu_pkg::opcode_e op,
		input logic [11:0] target);
		return {op, target};
	endfunction

	task automatic emit(input cpu_pkg::word_t inst);
		if (prog_len >= data_base) begin
			$display("error: test program runs into the data area");
			abort_run();
		end else begin
			image[prog_len] = inst;
			prog_len++;
		end
	endtask

	// lhi then ori gives any 16-bit value
	task automatic load_word(input cpu_pkg::reg_addr_t r, input cpu_pkg::word_t value);
		emit(encode_i(cpu_pkg::op_lhi, 2'd0, r, value[15:8]));
		emit(encode_i(cpu_pkg::op_ori, r, r, value[7:0]));
	endtask

	task automatic build_program();
		cpu_pkg::opcode_e i_ops [3];
		cpu_pkg::func_e r_funcs [8];
		cpu_pkg::opcode_e b_ops [4];
		logic [7:0] offsets [4];
		cpu_pkg::reg_addr_t rs;
		cpu_pkg::reg_addr_t rt;
		cpu_pkg::reg_addr_t rd;
		cpu_pkg::word_t v0;
		cpu_pkg::word_t v1;
		logic taken;
		int sel;
		int p;

		i_ops = '{cpu_pkg::op_adi, cpu_pkg::op_ori, cpu_pkg::op_lhi};
		r_funcs = '{cpu_pkg::fn_add, cpu_pkg::fn_sub, cpu_pkg::fn_and, cpu_pkg::fn_orr,
			cpu_pkg::fn_not, cpu_pkg::fn_tcp, cpu_pkg::fn_shl, cpu_pkg::fn_shr};
		b_ops = '{cpu_pkg::op_bne, cpu_pkg::op_beq, cpu_pkg::op_bgz, cpu_pkg::op_blz};
		for (int i = 0; i < mem_words; i++) begin
			image[i] = {i[7:0], ~i[7:0]};
		end
		prog_len = 0;

		// give every register a known value first
		for (int r = 0; r < cpu_pkg::reg_count; r++) begin
			load_word(cpu_pkg::reg_addr_t'(r), random_bits(16));
			emit(encode_r(cpu_pkg::fn_wwd, cpu_pkg::reg_addr_t'(r), 2'd0, 2'd0));
		end
		for (int k = 0; k < 6; k++) begin
			sel = int'(random_bits(2)) % 3;
			rs = cpu_pkg::reg_addr_t'(random_bits(2));
			rt = cpu_pkg::reg_addr_t'(random_bits(2));
			emit(encode_i(i_ops[sel], rs, rt, 8'(random_bits(8))));
			emit(encode_r(cpu_pkg::fn_wwd, rt, 2'd0, 2'd0));
		end
		foreach (r_funcs[k]) begin
			rs = cpu_pkg::reg_addr_t'(random_bits(2));
			rt = cpu_pkg::reg_addr_t'(random_bits(2));
			rd = cpu_pkg::reg_addr_t'(random_bits(2));
			emit(encode_r(r_funcs[k], rs, rt, rd));
			emit(encode_r(cpu_pkg::fn_wwd, rd, 2'd0, 2'd0));
		end

		// stores and loads through r3 as base
		load_word(2'd3, cpu_pkg::word_t'(data_base));
		foreach (offsets[k]) begin
			offsets[k] = {2'b00, 6'(random_bits(6))};
			rt = cpu_pkg::reg_addr_t'(random_bits(2) % 3);
			emit(encode_i(cpu_pkg::op_swd, 2'd3, rt, offsets[k]));
		end
		foreach (offsets[k]) begin
			rt = cpu_pkg::reg_addr_t'(random_bits(2) % 3);
			emit(encode_i(cpu_pkg::op_lwd, 2'd3, rt, offsets[k]));
			emit(encode_r(cpu_pkg::fn_wwd, rt, 2'd0, 2'd0));
		end

		// each branch taken once and not taken once
		// a taken branch skips the next two words
		for (int k = 0; k < 8; k++) begin
			v0 = random_bits(16);
			taken = (k % 2 == 0);
			case (b_ops[k / 2])
				cpu_pkg::op_bne: v1 = taken ? (v0 ^ 16'h0100) : v0;
				cpu_pkg::op_beq: v1 = taken ? v0 : (v0 ^ 16'h0001);
				cpu_pkg::op_bgz: begin
					v0 = taken ? ({1'b0, v0[14:0]} | 16'h0001) : '0;
					v1 = v0;
				end
				default: begin
					v0 = {taken, v0[14:0]};
					v1 = v0;
				end
			endcase
			load_word(2'd0, v0);
			load_word(2'd1, v1);
			emit(encode_i(b_ops[k / 2], 2'd0, 2'd1, 8'd2));
			emit(encode_i(cpu_pkg::op_lhi, 2'd0, 2'd2, 8'(8'h10 + 2 * k)));
			emit(encode_r(cpu_pkg::fn_wwd, 2'd2, 2'd0, 2'd0));
			emit(encode_i(cpu_pkg::op_lhi, 2'd0, 2'd2, 8'(8'h11 + 2 * k)));
			emit(encode_r(cpu_pkg::fn_wwd, 2'd2, 2'd0, 2'd0));
		end

		// words skipped by a jump would print a different value
		p = prog_len;
		emit(encode_j(cpu_pkg::op_jmp, 12'(p + 3)));
		emit(encode_i(cpu_pkg::op_lhi, 2'd0, 2'd2, 8'he0));
		emit(encode_r(cpu_pkg::fn_wwd, 2'd2, 2'd0, 2'd0));
		emit(encode_j(cpu_pkg::op_jal, 12'(p + 6)));
		emit(encode_i(cpu_pkg::op_lhi, 2'd0, 2'd2, 8'he1));
		emit(encode_r(cpu_pkg::fn_wwd, 2'd2, 2'd0, 2'd0));
		emit(encode_r(cpu_pkg::fn_wwd, 2'd2, 2'd0, 2'd0));
		load_word(2'd1, cpu_pkg::word_t'(p + 12));
		emit(encode_r(cpu_pkg::fn_jrl, 2'd1, 2'd0, 2'd0));
		emit(encode_i(cpu_pkg::op_lhi, 2'd0, 2'd2, 8'he2));
		emit(encode_r(cpu_pkg::fn_wwd, 2'd2, 2'd0, 2'd0));
		emit(encode_r(cpu_pkg::fn_wwd, 2'd2, 2'd0, 2'd0));
		load_word(2'd0, cpu_pkg::word_t'(p + 17));
		emit(encode_r(cpu_pkg::fn_jpr, 2'd0, 2'd0, 2'd0));
		emit(encode_r(cpu_pkg::fn_wwd, 2'd1, 2'd0, 2'd0));
		emit(encode_r(cpu_pkg::fn_wwd, 2'd0, 2'd0, 2'd0));
		emit(encode_r(cpu_pkg::fn_hlt, 2'd0, 2'd0, 2'd0));
	endtask

	initial begin : main_sequence
		cpu_pkg::word_t prev;

		reset_n = 1'b0;
		checking_port = 1'b0;
		counting = 1'b0;
		seen_port = '0;
		port_index = 0;
		cycle_count = 0;
		lfsr_state = lfsr_seed;
		build_program();
		mem = image;
		ref_run(image, ref_outs, ref_count, ref_halted, ref_mem);
		if (!ref_halted) begin
			$display("error: reference model did not reach hlt");
			abort_run();
		end
		// output_port is only seen when its value changes
		prev = '0;
		foreach (ref_outs[i]) begin
			if (ref_outs[i] != prev) begin
				expected_changes.push_back(ref_outs[i]);
				prev = ref_outs[i];
			end
		end
		cycle_limit = 5 * ref_count + 50;

		repeat (reset_cycles) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		compare_word("output_port after reset", output_port, '0);
		compare_word("num_inst after reset", num_inst, '0);
		compare_flag("is_halted after reset", is_halted, 1'b0);
		compare_flag("read_m after reset", read_m, 1'b1);
		compare_flag("write_m after reset", write_m, 1'b0);
		compare_word("address after reset", address, '0);
		checking_port = 1'b1;
		counting = 1'b1;

		while (is_halted !== 1'b1) begin
			@(negedge clk);
		end
		counting = 1'b0;
		repeat (halt_hold_cycles) begin
			@(negedge clk);
			compare_flag("is_halted while halted", is_halted, 1'b1);
			compare_flag("read_m while halted", read_m, 1'b0);
			compare_flag("write_m while halted", write_m, 1'b0);
		end
		compare_word("num_inst", num_inst, cpu_pkg::word_t'(ref_count));
		compare_word("output_port change count", cpu_pkg::word_t'(port_index),
			cpu_pkg::word_t'(expected_changes.size()));
		for (int i = 0; i < mem_words; i++) begin
			compare_word($sformatf("memory word %0d", i), mem[i], ref_mem[i]);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+verification
src/cpu_pkg.sv
src/cpu_ctrl_if.sv
src/register_file.sv
src/alu.sv
src/control_unit.sv
src/cpu.sv
verification/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - files:
      - src/cpu_pkg.sv
      - src/cpu_ctrl_if.sv
      - src/register_file.sv
      - src/alu.sv
      - src/control_unit.sv
      - src/cpu.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/cpu_tb.sv
